/* rtl/miss_pkg.sv */
// Sizes are fixed here for a four-thread core with 32-bit addresses; one queue entry per thread
`default_nettype none

package miss_pkg;

	// Hardware threads per core, also the number of miss queue entries
	localparam int THREADS_PER_CORE = 4;

	// Width of an address or a data word
	localparam int SCALAR_WIDTH = 32;

	// Index width derived from the thread count
	localparam int THREAD_IDX_WIDTH = $clog2(THREADS_PER_CORE);

	// Byte address or data word
	typedef logic [SCALAR_WIDTH - 1:0] scalar_t;

	// Hardware thread index
	typedef logic [THREAD_IDX_WIDTH - 1:0] thread_idx_t;

	// Miss queue entry index, one entry per thread
	typedef logic [THREAD_IDX_WIDTH - 1:0] miss_entry_idx_t;

	// One bit per thread, used for waiting sets and wakeups
	typedef logic [THREADS_PER_CORE - 1:0] thread_mask_t;

endpackage

`default_nettype wire

/* rtl/bus_pkg.sv */
// AXI4-Lite read side only; timeout counts cycles after the AR handshake and must fit timer_count_t
`default_nettype none

package bus_pkg;

	// AXI read response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

	// Fill FSM states
	typedef enum logic [2:0] {
		FILL_IDLE,
		FILL_ADDR,
		FILL_DATA,
		FILL_WAKE,
		FILL_DRAIN
	} fill_state_t;

	// Cycles to wait for read data once the address is accepted
	localparam int RESPONSE_TIMEOUT = 64;

	// Counter wide enough to hold RESPONSE_TIMEOUT
	typedef logic [$clog2(RESPONSE_TIMEOUT + 1) - 1:0] timer_count_t;

endpackage

`default_nettype wire

/* rtl/rr_arbiter.sv */
// Grant is combinational from request and pointer; pointer only moves when advance is high
`default_nettype none

module rr_arbiter (
	input  logic                      clk,
	input  logic                      reset,
	input  miss_pkg::thread_mask_t    request,
	input  logic                      advance,
	output miss_pkg::thread_mask_t    grant_oh,
	output miss_pkg::miss_entry_idx_t grant_idx
);

	// Entry with the highest priority this cycle
	miss_pkg::miss_entry_idx_t priority_ptr;

	// Scan from the pointer upward and wrap, first request wins
	always_comb
	begin
		miss_pkg::miss_entry_idx_t candidate;
		logic found;
		grant_oh = '0;
		grant_idx = '0;
		found = 1'b0;
		for (int offset = 0; offset < miss_pkg::THREADS_PER_CORE; offset++)
		begin
			// Two-bit add wraps around the entry count
			candidate = priority_ptr + miss_pkg::miss_entry_idx_t'(offset);
			if (!found && request[candidate])
			begin
				found = 1'b1;
				grant_oh[candidate] = 1'b1;
				grant_idx = candidate;
			end
		end
	end

	// Granted entry drops to lowest priority once it is taken
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			priority_ptr <= '0;
		else if (advance)
			priority_ptr <= grant_idx + miss_pkg::miss_entry_idx_t'(1);
	end

	// At most one grant, and advance only consumes a real grant
	assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant_oh) && (advance -> |grant_oh));

endmodule

`default_nettype wire

/* rtl/l1_miss_queue.sv */
// Core must not miss on a thread again before its wake, nor merge into an entry in its wake cycle
`default_nettype none

module l1_miss_queue (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      cache_miss,
	input  miss_pkg::scalar_t         cache_miss_addr,
	input  miss_pkg::thread_idx_t     cache_miss_thread_idx,
	input  logic                      cache_miss_synchronized,
	output logic                      dequeue_ready,
	input  logic                      dequeue_ack,
	output miss_pkg::scalar_t         dequeue_addr,
	output miss_pkg::miss_entry_idx_t dequeue_idx,
	input  logic                      wake_en,
	input  miss_pkg::miss_entry_idx_t wake_idx,
	output miss_pkg::thread_mask_t    wake_oh
);

	// Per-entry control state
	logic entry_valid [miss_pkg::THREADS_PER_CORE];
	logic entry_sent  [miss_pkg::THREADS_PER_CORE];

	// Per-entry payload
	miss_pkg::thread_mask_t entry_mask [miss_pkg::THREADS_PER_CORE];
	miss_pkg::scalar_t      entry_addr [miss_pkg::THREADS_PER_CORE];
	logic                   entry_sync [miss_pkg::THREADS_PER_CORE];

	miss_pkg::thread_mask_t    miss_thread_oh;
	miss_pkg::thread_mask_t    collided_oh;
	miss_pkg::thread_mask_t    send_request;
	miss_pkg::thread_mask_t    send_grant_oh;
	miss_pkg::miss_entry_idx_t send_grant_idx;
	logic                      allocate;

	// Thread that missed, as a mask bit
	assign miss_thread_oh = miss_pkg::thread_mask_t'(1) << cache_miss_thread_idx;

	// Match against pending entries; synchronized misses stay on their own
	always_comb
	begin
		for (int e = 0; e < miss_pkg::THREADS_PER_CORE; e++)
		begin
			collided_oh[e] = entry_valid[e] && entry_addr[e] == cache_miss_addr
				&& !entry_sync[e] && !cache_miss_synchronized;
			// Only entries not yet on the bus compete for the send slot
			send_request[e] = entry_valid[e] && !entry_sent[e];
		end
	end

	// No match means the miss takes its own thread's slot
	assign allocate = cache_miss && !(|collided_oh);

	rr_arbiter i_send_arbiter (
		.clk       (clk),
		.reset     (reset),
		.request   (send_request),
		.advance   (dequeue_ack),
		.grant_oh  (send_grant_oh),
		.grant_idx (send_grant_idx)
	);

	assign dequeue_ready = |send_request;
	assign dequeue_addr = entry_addr[send_grant_idx];
	assign dequeue_idx = send_grant_idx;

	// Wake everyone merged into the finished entry
	assign wake_oh = wake_en ? entry_mask[wake_idx] : '0;

	// Entry lifecycle: allocate, send, free on wake
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int e = 0; e < miss_pkg::THREADS_PER_CORE; e++)
			begin
				entry_valid[e] <= 1'b0;
				entry_sent[e] <= 1'b0;
			end
		end
		else
		begin
			for (int e = 0; e < miss_pkg::THREADS_PER_CORE; e++)
			begin
				if (dequeue_ack && send_grant_oh[e])
					entry_sent[e] <= 1'b1;
				else if (allocate && miss_thread_oh[e])
				begin
					entry_valid[e] <= 1'b1;
					entry_sent[e] <= 1'b0;
				end
				else if (wake_en && wake_idx == miss_pkg::miss_entry_idx_t'(e))
					entry_valid[e] <= 1'b0;
			end
		end
	end

	// Address, flags and waiting set
	always_ff @(posedge clk)
	begin
		for (int e = 0; e < miss_pkg::THREADS_PER_CORE; e++)
		begin
			if (allocate && miss_thread_oh[e])
			begin
				entry_addr[e] <= cache_miss_addr;
				entry_sync[e] <= cache_miss_synchronized;
				entry_mask[e] <= miss_thread_oh;
			end
			else if (cache_miss && collided_oh[e])
			begin
				// Piggyback on the read already pending or in flight
				entry_mask[e] <= entry_mask[e] | miss_thread_oh;
			end
		end
	end

	// Slot of a non-merging miss must be free
	assert property (@(posedge clk) disable iff (reset)
		allocate |-> !entry_valid[cache_miss_thread_idx]);

	// FSM only takes entries that are waiting to be sent
	assert property (@(posedge clk) disable iff (reset)
		dequeue_ack |-> entry_valid[dequeue_idx] && !entry_sent[dequeue_idx]);

	// Merge into an entry being freed would lose the thread
	assert property (@(posedge clk) disable iff (reset)
		!(cache_miss && wake_en && collided_oh[wake_idx]));

endmodule

`default_nettype wire

/* rtl/fill_fsm.sv */
// One read in flight; after a timeout the late beat is drained before the next entry is taken
`default_nettype none

module fill_fsm (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      dequeue_ready,
	input  miss_pkg::scalar_t         dequeue_addr,
	input  miss_pkg::miss_entry_idx_t dequeue_idx,
	output logic                      dequeue_ack,
	output logic                      wake_en,
	output miss_pkg::miss_entry_idx_t wake_idx,
	output logic                      arvalid,
	input  logic                      arready,
	output miss_pkg::scalar_t         araddr,
	output logic [2:0]                arprot,
	input  logic                      rvalid,
	output logic                      rready,
	input  miss_pkg::scalar_t         rdata,
	input  bus_pkg::axi_resp_t        rresp,
	output logic                      timer_start,
	output logic                      timer_stop,
	input  logic                      timer_expired,
	output miss_pkg::scalar_t         fill_data,
	output logic                      fill_error
);

	bus_pkg::fill_state_t state;
	bus_pkg::fill_state_t next_state;

	// Set when the response timer fired, a beat is still owed
	logic timed_out;

	// Take an entry only when idle
	assign dequeue_ack = state == bus_pkg::FILL_IDLE && dequeue_ready;

	// Bus outputs follow the state
	assign arvalid = state == bus_pkg::FILL_ADDR;
	assign rready = state == bus_pkg::FILL_DATA || state == bus_pkg::FILL_DRAIN;
	// Unprivileged secure data access
	assign arprot = 3'b000;

	assign wake_en = state == bus_pkg::FILL_WAKE;

	// Timer covers the gap between the two handshakes
	assign timer_start = arvalid && arready;
	assign timer_stop = state == bus_pkg::FILL_DATA && rvalid;

	always_comb
	begin
		next_state = state;
		case (state)
			bus_pkg::FILL_IDLE:
				if (dequeue_ready)
					next_state = bus_pkg::FILL_ADDR;
			bus_pkg::FILL_ADDR:
				if (arready)
					next_state = bus_pkg::FILL_DATA;
			bus_pkg::FILL_DATA:
				if (rvalid || timer_expired)
					next_state = bus_pkg::FILL_WAKE;
			// Owed beat goes to drain, otherwise ready for the next entry
			bus_pkg::FILL_WAKE:
				next_state = timed_out ? bus_pkg::FILL_DRAIN : bus_pkg::FILL_IDLE;
			bus_pkg::FILL_DRAIN:
				if (rvalid)
					next_state = bus_pkg::FILL_IDLE;
			default:
				next_state = bus_pkg::FILL_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= bus_pkg::FILL_IDLE;
			timed_out <= 1'b0;
			fill_error <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (state == bus_pkg::FILL_DATA)
			begin
				// Data wins over an expiry in the same cycle
				if (rvalid)
					fill_error <= rresp != bus_pkg::OKAY;
				else if (timer_expired)
				begin
					fill_error <= 1'b1;
					timed_out <= 1'b1;
				end
			end
			// Late beat discarded here
			if (state == bus_pkg::FILL_DRAIN && rvalid)
				timed_out <= 1'b0;
		end
	end

	// Request address, wake target and returned word
	always_ff @(posedge clk)
	begin
		if (dequeue_ack)
		begin
			araddr <= dequeue_addr;
			wake_idx <= dequeue_idx;
		end
		if (state == bus_pkg::FILL_DATA)
		begin
			if (rvalid)
				fill_data <= rdata;
			else if (timer_expired)
				fill_data <= '0;
		end
	end

	// AR payload holds until accepted
	assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr));

	// Wake comes straight out of the data phase
	assert property (@(posedge clk) disable iff (reset)
		wake_en |-> state == bus_pkg::FILL_WAKE && $past(state) == bus_pkg::FILL_DATA);

endmodule

`default_nettype wire

/* rtl/response_timer.sv */
// Start has priority over stop; expiry pulses once, RESPONSE_TIMEOUT cycles after start
`default_nettype none

module response_timer (
	input  logic clk,
	input  logic reset,
	input  logic timer_start,
	input  logic timer_stop,
	output logic timer_expired
);

	logic                  armed;
	bus_pkg::timer_count_t count;

	// Fires in the cycle the count reaches zero
	assign timer_expired = armed && count == '0;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			armed <= 1'b0;
			count <= '0;
		end
		else if (timer_start)
		begin
			armed <= 1'b1;
			count <= bus_pkg::timer_count_t'(bus_pkg::RESPONSE_TIMEOUT);
		end
		// Early stop or single-cycle expiry pulse
		else if (timer_stop || timer_expired)
			armed <= 1'b0;
		else if (armed)
			count <= count - bus_pkg::timer_count_t'(1);
	end

endmodule

`default_nettype wire

/* rtl/miss_unit_top.sv */
// Miss input is a one-cycle pulse without back-pressure; wake_oh is valid only when non-zero
`default_nettype none

module miss_unit_top (
	input  logic                   clk,
	input  logic                   reset,

	// Core miss report
	input  logic                   cache_miss,
	input  miss_pkg::scalar_t      cache_miss_addr,
	input  miss_pkg::thread_idx_t  cache_miss_thread_idx,
	input  logic                   cache_miss_synchronized,

	// Core wakeup
	output miss_pkg::thread_mask_t wake_oh,
	output miss_pkg::scalar_t      fill_data,
	output logic                   fill_error,

	// AXI4-Lite read address channel
	output logic                   arvalid,
	input  logic                   arready,
	output miss_pkg::scalar_t      araddr,
	output logic [2:0]             arprot,

	// AXI4-Lite read data channel
	input  logic                   rvalid,
	output logic                   rready,
	input  miss_pkg::scalar_t      rdata,
	input  bus_pkg::axi_resp_t     rresp
);

	logic                      dequeue_ready;
	logic                      dequeue_ack;
	miss_pkg::scalar_t         dequeue_addr;
	miss_pkg::miss_entry_idx_t dequeue_idx;
	logic                      wake_en;
	miss_pkg::miss_entry_idx_t wake_idx;
	logic                      timer_start;
	logic                      timer_stop;
	logic                      timer_expired;

	l1_miss_queue i_l1_miss_queue (
		.clk                     (clk),
		.reset                   (reset),
		.cache_miss              (cache_miss),
		.cache_miss_addr         (cache_miss_addr),
		.cache_miss_thread_idx   (cache_miss_thread_idx),
		.cache_miss_synchronized (cache_miss_synchronized),
		.dequeue_ready           (dequeue_ready),
		.dequeue_ack             (dequeue_ack),
		.dequeue_addr            (dequeue_addr),
		.dequeue_idx             (dequeue_idx),
		.wake_en                 (wake_en),
		.wake_idx                (wake_idx),
		.wake_oh                 (wake_oh)
	);

	fill_fsm i_fill_fsm (
		.clk           (clk),
		.reset         (reset),
		.dequeue_ready (dequeue_ready),
		.dequeue_addr  (dequeue_addr),
		.dequeue_idx   (dequeue_idx),
		.dequeue_ack   (dequeue_ack),
		.wake_en       (wake_en),
		.wake_idx      (wake_idx),
		.arvalid       (arvalid),
		.arready       (arready),
		.araddr        (araddr),
		.arprot        (arprot),
		.rvalid        (rvalid),
		.rready        (rready),
		.rdata         (rdata),
		.rresp         (rresp),
		.timer_start   (timer_start),
		.timer_stop    (timer_stop),
		.timer_expired (timer_expired),
		.fill_data     (fill_data),
		.fill_error    (fill_error)
	);

	response_timer i_response_timer (
		.clk           (clk),
		.reset         (reset),
		.timer_start   (timer_start),
		.timer_stop    (timer_stop),
		.timer_expired (timer_expired)
	);

endmodule

`default_nettype wire

/* bench/axi_lite_mem.sv */
// Read-only AXI4-Lite slave for one outstanding read; bit 30 of the address gives SLVERR, bit 29 a late beat
`default_nettype none

module axi_lite_mem (
	input  logic               clk,
	input  logic               reset,
	input  logic               arvalid,
	output logic               arready,
	input  miss_pkg::scalar_t  araddr,
	output logic               rvalid,
	input  logic               rready,
	output miss_pkg::scalar_t  rdata,
	output bus_pkg::axi_resp_t rresp
);

	timeunit 1ns;
	timeprecision 1ns;

	// Handshakes seen at the last rising edge
	logic ar_fire;
	logic r_fire;

	// Accepted read still owes its data beat
	logic              pending;
	miss_pkg::scalar_t addr_q;
	int                ar_wait;
	int                r_wait;

	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ar_fire <= 1'b0;
			r_fire <= 1'b0;
		end
		else
		begin
			ar_fire <= arvalid && arready;
			r_fire <= rvalid && rready;
		end
	end

	// Outputs change on the falling edge only
	always @(negedge clk or posedge reset)
	begin
		if (reset)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= bus_pkg::OKAY;
			pending <= 1'b0;
			addr_q <= '0;
			ar_wait <= 0;
			r_wait <= 0;
		end
		else
		begin
			// Address channel
			if (ar_fire)
			begin
				arready <= 1'b0;
				pending <= 1'b1;
				// Bit 29 outlasts the response timer
				r_wait <= addr_q[29] ? 100 : $urandom_range(5, 0);
				ar_wait <= $urandom_range(5, 0);
			end
			else if (arvalid && !arready && !pending)
			begin
				if (ar_wait == 0)
				begin
					arready <= 1'b1;
					addr_q <= araddr;
				end
				else
					ar_wait <= ar_wait - 1;
			end
			// Data channel
			if (r_fire)
			begin
				rvalid <= 1'b0;
				pending <= 1'b0;
			end
			else if (pending && !rvalid)
			begin
				if (r_wait == 0)
				begin
					rvalid <= 1'b1;
					rdata <= addr_q ^ 32'h5a5a5a5a;
					rresp <= addr_q[30] ? bus_pkg::SLVERR : bus_pkg::OKAY;
				end
				else
					r_wait <= r_wait - 1;
			end
		end
	end

endmodule

`default_nettype wire

/* bench/miss_unit_tb.sv */
// Drives misses on the falling edge; a thread never misses again before its wake, nor during a wake cycle
`default_nettype none

module miss_unit_tb;

	timeunit 1ns;
	timeprecision 1ns;

	logic                   clk;
	logic                   reset;
	logic                   cache_miss;
	miss_pkg::scalar_t      cache_miss_addr;
	miss_pkg::thread_idx_t  cache_miss_thread_idx;
	logic                   cache_miss_synchronized;
	miss_pkg::thread_mask_t wake_oh;
	miss_pkg::scalar_t      fill_data;
	logic                   fill_error;
	logic                   arvalid;
	logic                   arready;
	miss_pkg::scalar_t      araddr;
	logic [2:0]             arprot;
	logic                   rvalid;
	logic                   rready;
	miss_pkg::scalar_t      rdata;
	bus_pkg::axi_resp_t     rresp;

	// Shadow of what each thread waits for
	miss_pkg::thread_mask_t shadow_pending;
	miss_pkg::thread_mask_t shadow_sync;
	miss_pkg::scalar_t      shadow_addr [miss_pkg::THREADS_PER_CORE];
	int                     read_count;
	int                     wake_count;
	miss_pkg::thread_mask_t last_wake;

	// Expected wake result, from the first woken thread
	miss_pkg::thread_idx_t  lead;
	miss_pkg::scalar_t      expect_data;
	logic                   expect_error;
	logic                   addr_spread;
	logic                   ar_known;

	int   errors;
	logic hung;
	logic quiet_window;

	miss_unit_top i_miss_unit_top (
		.clk                     (clk),
		.reset                   (reset),
		.cache_miss              (cache_miss),
		.cache_miss_addr         (cache_miss_addr),
		.cache_miss_thread_idx   (cache_miss_thread_idx),
		.cache_miss_synchronized (cache_miss_synchronized),
		.wake_oh                 (wake_oh),
		.fill_data               (fill_data),
		.fill_error              (fill_error),
		.arvalid                 (arvalid),
		.arready                 (arready),
		.araddr                  (araddr),
		.arprot                  (arprot),
		.rvalid                  (rvalid),
		.rready                  (rready),
		.rdata                   (rdata),
		.rresp                   (rresp)
	);

	axi_lite_mem i_axi_lite_mem (
		.clk     (clk),
		.reset   (reset),
		.arvalid (arvalid),
		.arready (arready),
		.araddr  (araddr),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.rresp   (rresp)
	);

	always #10 clk = ~clk;

	// Memory rule: XOR pattern, late beat returns zero
	function automatic miss_pkg::scalar_t predict_fill_data(input miss_pkg::scalar_t addr);
		return addr[29] ? '0 : addr ^ 32'h5a5a5a5a;
	endfunction

	// Timeout or slave error
	function automatic logic predict_fill_error(input miss_pkg::scalar_t addr);
		return addr[29] || addr[30];
	endfunction

	// Shadow update at each rising edge
	always @(posedge clk or posedge reset)
	begin
		miss_pkg::thread_mask_t next_pending;
		if (reset)
		begin
			shadow_pending <= '0;
			shadow_sync <= '0;
			read_count <= 0;
			wake_count <= 0;
			last_wake <= '0;
		end
		else
		begin
			next_pending = shadow_pending & ~wake_oh;
			if (arvalid && arready)
				read_count <= read_count + 1;
			if (wake_oh != '0)
			begin
				wake_count <= wake_count + 1;
				last_wake <= wake_oh;
			end
			if (cache_miss)
			begin
				next_pending[cache_miss_thread_idx] = 1'b1;
				shadow_addr[cache_miss_thread_idx] <= cache_miss_addr;
				shadow_sync[cache_miss_thread_idx] <= cache_miss_synchronized;
			end
			shadow_pending <= next_pending;
		end
	end

	always_comb
	begin
		logic found;
		found = 1'b0;
		lead = '0;
		for (int t = 0; t < miss_pkg::THREADS_PER_CORE; t++)
		begin
			if (!found && wake_oh[t])
			begin
				found = 1'b1;
				lead = miss_pkg::thread_idx_t'(t);
			end
		end
		expect_data = predict_fill_data(shadow_addr[lead]);
		expect_error = predict_fill_error(shadow_addr[lead]);
		addr_spread = 1'b0;
		ar_known = 1'b0;
		for (int t = 0; t < miss_pkg::THREADS_PER_CORE; t++)
		begin
			// Merged threads must share one address
			if (wake_oh[t] && shadow_addr[t] != shadow_addr[lead])
				addr_spread = 1'b1;
			if (shadow_pending[t] && shadow_addr[t] == araddr)
				ar_known = 1'b1;
		end
	end

	// Bus and wake stay quiet in and just after reset
	assert property (@(posedge clk) quiet_window |-> wake_oh == '0 && !arvalid && !rready)
	else
	begin
		errors++;
		$display("error reset outputs: wake_oh %h arvalid %h rready %h",
			$sampled(wake_oh), $sampled(arvalid), $sampled(rready));
	end

	assert property (@(posedge clk) disable iff (reset) wake_oh != '0 |-> fill_data == expect_data)
	else
	begin
		errors++;
		$display("error fill_data: got %h, expected %h", $sampled(fill_data),
			$sampled(expect_data));
	end

	assert property (@(posedge clk) disable iff (reset) wake_oh != '0 |-> fill_error == expect_error)
	else
	begin
		errors++;
		$display("error fill_error: got %h, expected %h", $sampled(fill_error),
			$sampled(expect_error));
	end

	// A thread is woken once per miss
	assert property (@(posedge clk) disable iff (reset)
		wake_oh != '0 |-> (wake_oh & ~shadow_pending) == '0 && !addr_spread)
	else
	begin
		errors++;
		$display("error wake_oh: got %h, waiting threads %h", $sampled(wake_oh),
			$sampled(shadow_pending));
	end

	// Synchronized misses wake alone
	assert property (@(posedge clk) disable iff (reset)
		(wake_oh & shadow_sync) != '0 |-> $onehot(wake_oh))
	else
	begin
		errors++;
		$display("error wake_oh: %h merged a synchronized miss", $sampled(wake_oh));
	end

	assert property (@(posedge clk) disable iff (reset) arvalid && arready |-> ar_known)
	else
	begin
		errors++;
		$display("error araddr: %h matches no pending miss", $sampled(araddr));
	end

	// Plain unprivileged data access on every read request
	assert property (@(posedge clk) disable iff (reset) arvalid |-> arprot == 3'b000)
	else
	begin
		errors++;
		$display("error arprot: got %h, expected %h", $sampled(arprot), 3'b000);
	end

	// One-cycle miss pulse, back to back when called in a row
	task automatic issue_miss(input miss_pkg::thread_idx_t thread, input miss_pkg::scalar_t addr,
		input logic sync);
		cache_miss = 1'b1;
		cache_miss_thread_idx = thread;
		cache_miss_addr = addr;
		cache_miss_synchronized = sync;
		@(negedge clk);
		cache_miss = 1'b0;
		cache_miss_synchronized = 1'b0;
	endtask

	task automatic wait_all_woken(input int limit);
		int cycles;
		for (cycles = 0; cycles < limit && shadow_pending != '0; cycles++)
			@(negedge clk);
		if (shadow_pending != '0)
		begin
			errors++;
			hung = 1'b1;
			$display("timeout: threads %b got no wake within %0d cycles", shadow_pending, limit);
		end
	endtask

	// Zero for exp_last skips the mask compare
	task automatic check_counts(input int reads_before, input int wakes_before, input int exp_reads,
		input int exp_wakes, input miss_pkg::thread_mask_t exp_last);
		assert (read_count - reads_before == exp_reads)
		else
		begin
			errors++;
			$display("error read count: got %h, expected %h", read_count - reads_before, exp_reads);
		end
		assert (wake_count - wakes_before == exp_wakes)
		else
		begin
			errors++;
			$display("error wake count: got %h, expected %h", wake_count - wakes_before, exp_wakes);
		end
		if (exp_last != '0)
			assert (last_wake == exp_last)
			else
			begin
				errors++;
				$display("error wake_oh: got %h, expected %h", last_wake, exp_last);
			end
	endtask

	task automatic directed_tests;
		int r0;
		int w0;
		// Single miss
		r0 = read_count;
		w0 = wake_count;
		issue_miss(2'd0, 32'h0000_2040, 1'b0);
		wait_all_woken(100);
		check_counts(r0, w0, 1, 1, 4'b0001);
		// Three threads merge into one read
		r0 = read_count;
		w0 = wake_count;
		issue_miss(2'd1, 32'h0000_3080, 1'b0);
		issue_miss(2'd2, 32'h0000_3080, 1'b0);
		issue_miss(2'd3, 32'h0000_3080, 1'b0);
		wait_all_woken(100);
		check_counts(r0, w0, 1, 1, 4'b1110);
		// Synchronized ones stay apart, the plain one as well
		r0 = read_count;
		w0 = wake_count;
		issue_miss(2'd0, 32'h0000_40c0, 1'b1);
		issue_miss(2'd1, 32'h0000_40c0, 1'b1);
		issue_miss(2'd2, 32'h0000_40c0, 1'b0);
		wait_all_woken(200);
		check_counts(r0, w0, 3, 3, '0);
		// Slave error
		r0 = read_count;
		w0 = wake_count;
		issue_miss(2'd3, 32'h4000_3000, 1'b0);
		wait_all_woken(100);
		check_counts(r0, w0, 1, 1, 4'b1000);
		// Timeout with a merge, then a normal read behind the drain
		r0 = read_count;
		w0 = wake_count;
		issue_miss(2'd0, 32'h2000_4000, 1'b0);
		issue_miss(2'd1, 32'h2000_4000, 1'b0);
		issue_miss(2'd2, 32'h0000_5000, 1'b0);
		wait_all_woken(400);
		check_counts(r0, w0, 2, 2, 4'b0100);
	endtask

	task automatic random_run;
		int issued;
		int cycles;
		miss_pkg::thread_idx_t t;
		miss_pkg::scalar_t addr;
		issued = 0;
		for (cycles = 0; cycles < 20000 && issued < 300; cycles++)
		begin
			t = miss_pkg::thread_idx_t'($urandom_range(3, 0));
			// Small pool so merges happen often
			addr = 32'h0000_1000 | (miss_pkg::scalar_t'($urandom_range(7, 0)) << 4);
			if ($urandom_range(15, 0) == 0)
				addr = addr | 32'h4000_0000;
			if (!shadow_pending[t] && wake_oh == '0 && $urandom_range(1, 0) == 1)
			begin
				cache_miss = 1'b1;
				cache_miss_thread_idx = t;
				cache_miss_addr = addr;
				cache_miss_synchronized = $urandom_range(3, 0) == 0;
				issued++;
			end
			else
				cache_miss = 1'b0;
			@(negedge clk);
		end
		cache_miss = 1'b0;
		cache_miss_synchronized = 1'b0;
		if (issued < 300)
		begin
			errors++;
			hung = 1'b1;
			$display("timeout: random run issued only %0d of 300 misses", issued);
		end
		else
			wait_all_woken(2000);
	endtask

	initial
	begin
		void'($urandom(32'hb83e));
		errors = 0;
		hung = 1'b0;
		quiet_window = 1'b0;
		clk = 1'b0;
		reset = 1'b1;
		cache_miss = 1'b0;
		cache_miss_addr = '0;
		cache_miss_thread_idx = '0;
		cache_miss_synchronized = 1'b0;
		@(negedge clk);
		quiet_window = 1'b1;
		repeat (9) @(negedge clk);
		reset = 1'b0;
		repeat (5) @(negedge clk);
		quiet_window = 1'b0;
		directed_tests();
		if (!hung)
			random_run();
		repeat (5) @(negedge clk);
		$display("errors: %0d  bus reads: %0d  wakes: %0d", errors, read_count, wake_count);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
rtl/miss_pkg.sv
rtl/bus_pkg.sv
rtl/rr_arbiter.sv
rtl/l1_miss_queue.sv
rtl/fill_fsm.sv
rtl/response_timer.sv
rtl/miss_unit_top.sv
bench/axi_lite_mem.sv
bench/miss_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the miss unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module miss_unit_tb -f tb.f
./obj_dir/Vmiss_unit_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
